//--- common/hispi_clk_pkg.sv
////////////////////////////////////////
// shared types, register map, latencies
// and sequencer states
////////////////////////////////////////
package hispi_clk_pkg;

    // widths with a meaning
    typedef logic [7:0]  phase_t;   // phase position in shift steps
    typedef logic [31:0] wb_data_t; // wishbone data word
    typedef logic [1:0]  wb_adr_t;  // register word address

    // register map, word addresses
    localparam wb_adr_t REG_PHASE   = 2'd0; // target phase, rw
    localparam wb_adr_t REG_CTRL    = 2'd1; // bit 0 rst_mmcm, rw
    localparam wb_adr_t REG_STATUS  = 2'd2; // bit 0 locked, bit 1 ps_rdy, ro
    localparam wb_adr_t REG_CURRENT = 2'd3; // current phase, ro

    // ctrl and status bit positions
    localparam int CTRL_RST_BIT   = 0;
    localparam int STAT_LOCK_BIT  = 0;
    localparam int STAT_RDY_BIT   = 1;

    // step request to done, in mclk cycles
    localparam byte unsigned PS_LATENCY = 8'd12;

    // clock manager reset release to locked, in mclk cycles
    localparam int LOCK_CYCLES = 64;

    // counter widths sized for the reload values
    localparam int PS_CNT_W   = $clog2(int'(PS_LATENCY)); // holds PS_LATENCY-1
    localparam int LOCK_CNT_W = $clog2(LOCK_CYCLES);      // holds LOCK_CYCLES-1

    // phase step sequencer
    typedef enum logic [1:0] {
        ST_IDLE, // compare current and target
        ST_REQ,  // one cycle step request
        ST_WAIT  // wait for the port to finish
    } step_state_t;

endpackage

//--- verilog/hispi_wb_regs.sv
////////////////////////////////////////
// wishbone classic register file
////////////////////////////////////////
`timescale 1ns/1ps

module hispi_wb_regs
    import hispi_clk_pkg::*;
(
    input  logic     mclk_i,
    input  logic     reset_i,
    // wishbone slave
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_adr_t  wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    // status from the clock logic
    input  logic     locked_i,
    input  logic     ps_rdy_i,
    input  phase_t   current_phase_i,
    // control to the clock logic
    output phase_t   target_phase_o,
    output logic     rst_mmcm_o
);

    logic     access;   // new cycle seen, ack not yet given
    logic     wr_en;
    wb_data_t rd_data;
    phase_t   target_phase;
    logic     rst_mmcm;
    logic     ack;

    assign access = wb_cyc_i & wb_stb_i & ~ack;
    assign wr_en  = access & wb_we_i;

    // single cycle ack, one per access
    always_ff @(posedge mclk_i) begin
        if (reset_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // writable registers, ro addresses ignored
    always_ff @(posedge mclk_i) begin
        if (reset_i) begin
            target_phase <= '0;
            rst_mmcm     <= 1'b1;   // clock manager held in reset
        end else if (wr_en) begin
            case (wb_adr_i)
                REG_PHASE: target_phase <= wb_dat_i[$bits(phase_t)-1:0];
                REG_CTRL:  rst_mmcm     <= wb_dat_i[CTRL_RST_BIT];
                default: ;          // status and current are ro
            endcase
        end
    end

    // read mux, unused bits stay 0
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            REG_PHASE:   rd_data[$bits(phase_t)-1:0] = target_phase;
            REG_CTRL:    rd_data[CTRL_RST_BIT]       = rst_mmcm;
            REG_STATUS: begin
                rd_data[STAT_LOCK_BIT] = locked_i;
                rd_data[STAT_RDY_BIT]  = ps_rdy_i;
            end
            REG_CURRENT: rd_data[$bits(phase_t)-1:0] = current_phase_i;
            default:     rd_data = '0;
        endcase
    end

    // read data captured with the ack
    always_ff @(posedge mclk_i) begin
        if (access) begin
            wb_dat_o <= rd_data;
        end
    end

    assign wb_ack_o       = ack;
    assign target_phase_o = target_phase;
    assign rst_mmcm_o     = rst_mmcm;

endmodule

//--- verilog/lock_monitor.sv
////////////////////////////////////////
// clock manager lock timer
////////////////////////////////////////
`timescale 1ns/1ps

module lock_monitor
    import hispi_clk_pkg::*;
(
    input  logic mclk_i,
    input  logic reset_i,
    input  logic rst_mmcm_i, // clock manager reset
    output logic locked_o
);

    logic [LOCK_CNT_W-1:0] lock_cnt;
    logic                  locked;

    // reloads while in reset, locked when the count has run out
    always_ff @(posedge mclk_i) begin
        if (reset_i || rst_mmcm_i) begin
            lock_cnt <= LOCK_CNT_W'(LOCK_CYCLES - 1);
            locked   <= 1'b0;
        end else if (lock_cnt != '0) begin
            lock_cnt <= lock_cnt - 1'b1;
        end else begin
            locked   <= 1'b1;   // LOCK_CYCLES edges after release
        end
    end

    assign locked_o = locked;

endmodule

//--- phase/phase_step_fsm.sv
////////////////////////////////////////
// phase step sequencer FSM
////////////////////////////////////////
`timescale 1ns/1ps

module phase_step_fsm
    import hispi_clk_pkg::*;
(
    input  logic   mclk_i,
    input  logic   reset_i,
    input  logic   locked_i,        // clock manager locked
    input  phase_t target_phase_i,  // from the register file
    input  phase_t current_phase_i, // from the phase port
    input  logic   ps_done_i,       // step finished
    output logic   ps_en_o,         // one cycle step request
    output logic   ps_incdec_o,     // 1 = increment
    output logic   ps_rdy_o         // phase settled on target
);

    step_state_t state;
    step_state_t state_nxt;
    logic        incdec;
    logic        phase_match;
    logic        go_up;

    assign phase_match = (current_phase_i == target_phase_i);
    assign go_up       = (target_phase_i > current_phase_i);

    always_comb begin
        state_nxt = state;
        if (!locked_i) begin
            state_nxt = ST_IDLE;    // lock lost, drop the move
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!phase_match) begin
                        state_nxt = ST_REQ;
                    end
                end
                ST_REQ: begin
                    state_nxt = ST_WAIT;
                end
                ST_WAIT: begin
                    if (ps_done_i) begin
                        state_nxt = ST_IDLE;
                    end
                end
                default: begin
                    state_nxt = ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge mclk_i) begin
        if (reset_i) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // direction picked when a step starts, target changes wait for idle
    always_ff @(posedge mclk_i) begin
        if (reset_i) begin
            incdec <= 1'b0;
        end else if (state == ST_IDLE && state_nxt == ST_REQ) begin
            incdec <= go_up;
        end
    end

    assign ps_en_o     = (state == ST_REQ);
    assign ps_incdec_o = incdec;
    assign ps_rdy_o    = (state == ST_IDLE) & locked_i & phase_match;

endmodule

//--- phase/phase_shift_port.sv
////////////////////////////////////////
// dynamic phase shift port model
////////////////////////////////////////
`timescale 1ns/1ps

module phase_shift_port
    import hispi_clk_pkg::*;
(
    input  logic   mclk_i,
    input  logic   reset_i,
    input  logic   rst_mmcm_i,      // back to configured phase
    input  logic   ps_en_i,         // step request
    input  logic   ps_incdec_i,     // 1 = increment
    output logic   ps_done_o,       // one cycle, PS_LATENCY after ps_en
    output phase_t current_phase_o
);

    logic [PS_CNT_W-1:0] lat_cnt;
    logic                busy;
    logic                dir_up;    // direction of the step in flight
    logic                fire;
    phase_t              phase;

    assign fire = busy & (lat_cnt == PS_CNT_W'(1));

    always_ff @(posedge mclk_i) begin
        if (reset_i || rst_mmcm_i) begin
            busy      <= 1'b0;
            lat_cnt   <= '0;
            dir_up    <= 1'b0;
            ps_done_o <= 1'b0;
            phase     <= '0;
        end else begin
            ps_done_o <= fire;
            if (ps_en_i && !busy) begin
                busy    <= 1'b1;
                lat_cnt <= PS_CNT_W'(PS_LATENCY - 8'd1);
                dir_up  <= ps_incdec_i;
            end else if (fire) begin
                busy  <= 1'b0;
                phase <= dir_up ? phase + 1'b1 : phase - 1'b1; // moves with done
            end else if (busy) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    assign current_phase_o = phase;

endmodule

//--- verilog/sens_hispi_clock_ctrl.sv
////////////////////////////////////////
// pixel clock control top level
////////////////////////////////////////
`timescale 1ns/1ps

module sens_hispi_clock_ctrl
    import hispi_clk_pkg::*;
(
    input  logic     mclk_i,
    input  logic     reset_i,
    // wishbone classic host port
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    input  logic     wb_we_i,
    input  wb_adr_t  wb_adr_i,
    input  wb_data_t wb_dat_i,
    output wb_data_t wb_dat_o,
    output logic     wb_ack_o,
    // status
    output logic     locked_o,
    output logic     ps_rdy_o,
    output phase_t   ps_out_o   // current phase
);

    phase_t target_phase;
    logic   rst_mmcm;
    logic   ps_en;
    logic   ps_incdec;
    logic   ps_done;

    hispi_wb_regs regs_i (
        .mclk_i          (mclk_i),
        .reset_i         (reset_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o),
        .locked_i        (locked_o),
        .ps_rdy_i        (ps_rdy_o),
        .current_phase_i (ps_out_o),
        .target_phase_o  (target_phase),
        .rst_mmcm_o      (rst_mmcm)
    );

    lock_monitor lock_i (
        .mclk_i     (mclk_i),
        .reset_i    (reset_i),
        .rst_mmcm_i (rst_mmcm),
        .locked_o   (locked_o)
    );

    phase_step_fsm step_i (
        .mclk_i          (mclk_i),
        .reset_i         (reset_i),
        .locked_i        (locked_o),
        .target_phase_i  (target_phase),
        .current_phase_i (ps_out_o),
        .ps_done_i       (ps_done),
        .ps_en_o         (ps_en),
        .ps_incdec_o     (ps_incdec),
        .ps_rdy_o        (ps_rdy_o)
    );

    phase_shift_port ps_port_i (
        .mclk_i          (mclk_i),
        .reset_i         (reset_i),
        .rst_mmcm_i      (rst_mmcm),
        .ps_en_i         (ps_en),
        .ps_incdec_i     (ps_incdec),
        .ps_done_o       (ps_done),
        .current_phase_o (ps_out_o)
    );

endmodule

//--- tests/tb_wb_tasks.svh
////////////////////////////////////////
// wishbone classic read and write tasks
////////////////////////////////////////

localparam int ACK_LIMIT = 8;   // cycles before a missing ack is reported

int ack_cycle = 0;              // cycle count at the last ack

// waits for ack, ends the cycle and checks that ack drops again
task automatic finish_access(output wb_data_t data);
    int tries;
    tries = 0;
    data  = '0;
    do begin
        @(negedge mclk);
        tries++;
    end while (!wb_ack && tries < ACK_LIMIT);
    if (!wb_ack) begin
        errors++;
        $display("Wishbone access to address %0d got no ack", wb_adr);
    end
    check(tries == 2, $sformatf("ack came %0d cycles after the request, expected 1",
                                tries - 1));
    data      = wb_rdat;        // read data valid with ack
    ack_cycle = cyc_cnt;
    @(posedge mclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge mclk);
    check(!wb_ack, "ack held for more than one cycle");
endtask

task automatic wb_write(input wb_adr_t adr, input wb_data_t data);
    wb_data_t ignored;
    @(posedge mclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b1;
    wb_adr <= adr;
    wb_dat <= data;
    finish_access(ignored);
endtask

task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
    @(posedge mclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    finish_access(data);
endtask

//--- tests/tb_hispi_clock.sv
////////////////////////////////////////
// testbench for the pixel clock control
// with watchdog and random phase targets
////////////////////////////////////////
`timescale 1ns/1ps

module tb_hispi_clock
    import hispi_clk_pkg::*;
();

    localparam int STEP_LIMIT      = int'(PS_LATENCY) + 3;   // worst cycles per step
    localparam int MOVE_LIMIT      = 256 * STEP_LIMIT;
    localparam int NUM_RANDOM      = 6;
    localparam int NUM_MOVES       = NUM_RANDOM + 6;         // directed moves and relocks
    localparam int WATCHDOG_CYCLES = NUM_MOVES * (LOCK_CYCLES + MOVE_LIMIT) + 2000;

    logic        mclk = 1'b0;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_adr_t     wb_adr;
    wb_data_t    wb_dat;
    wb_data_t    wb_rdat;
    logic        wb_ack;
    logic        locked;
    logic        ps_rdy;
    phase_t      ps_out;
    int          cyc_cnt = 0;
    int          errors  = 0;
    int          checks  = 0;
    logic [31:0] lfsr    = 32'hca0a;

    sens_hispi_clock_ctrl uut (
        .mclk_i   (mclk),
        .reset_i  (reset),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat),
        .wb_dat_o (wb_rdat),
        .wb_ack_o (wb_ack),
        .locked_o (locked),
        .ps_rdy_o (ps_rdy),
        .ps_out_o (ps_out)
    );

    always #50 mclk = ~mclk;                // 100 ns period

    always @(posedge mclk) cyc_cnt++;

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("** Error at %0t ns: %s", $time, msg);
        end
    endtask

    `include "tb_wb_tasks.svh"

    // galois form, taps of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_phase(output phase_t p);
        p = '0;
        for (int b = 0; b < $bits(phase_t); b++) begin
            lfsr = lfsr_next(lfsr);         // one step per bit
            p    = {p[6:0], lfsr[0]};
        end
    endtask

    // locked must rise exactly LOCK_CYCLES after the release write
    task automatic wait_lock();
        int start;
        start = ack_cycle;
        while (!locked && cyc_cnt - start <= LOCK_CYCLES + 8) begin
            @(negedge mclk);
        end
        check(locked === 1'b1 && cyc_cnt - start == LOCK_CYCLES,
              $sformatf("locked rose %0d cycles after release, expected %0d",
                        cyc_cnt - start, LOCK_CYCLES));
    endtask

    // follows the phase one step at a time until ps_rdy
    task automatic follow_move(input phase_t target);
        phase_t prev;
        phase_t exp_next;
        logic   up;
        int     gap;
        int     waited;
        prev   = ps_out;
        up     = (target > prev);
        gap    = 0;
        waited = 0;
        while (!ps_rdy && waited < MOVE_LIMIT) begin
            @(negedge mclk);
            waited++;
            gap++;
            if (ps_out != prev) begin
                exp_next = up ? prev + 8'd1 : prev - 8'd1;
                check(ps_out == exp_next, $sformatf("phase went %0d -> %0d, expected %0d",
                                                     prev, ps_out, exp_next));
                check(gap <= STEP_LIMIT, $sformatf("step took %0d cycles", gap));
                prev = ps_out;
                gap  = 0;
            end
        end
        if (!ps_rdy) begin
            errors++;
            $display("phase never settled on target %0d", target);
        end
        check(ps_out == target, $sformatf("phase %0d, target %0d", ps_out, target));
    endtask

    // registers must agree with the ports once settled
    task automatic check_readback(input phase_t target);
        wb_data_t rd;
        wb_read(REG_PHASE, rd);
        check(rd == {24'h0, target}, $sformatf("REG_PHASE reads %h", rd));
        wb_read(REG_STATUS, rd);
        check(rd == {30'h0, ps_rdy, locked} && rd == 32'd3,
              $sformatf("REG_STATUS reads %h", rd));
        wb_read(REG_CURRENT, rd);
        check(rd == {24'h0, ps_out}, $sformatf("REG_CURRENT reads %h, port %h", rd, ps_out));
    endtask

    task automatic move_to(input phase_t target);
        wb_write(REG_PHASE, {24'h0, target});
        follow_move(target);
        check_readback(target);
    endtask

    initial begin
        wb_data_t rd;
        wb_data_t status_before;
        wb_data_t current_before;
        phase_t   p;
        reset  <= 1'b1;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        wb_adr <= '0;
        wb_dat <= '0;
        repeat (10) @(posedge mclk);
        reset <= 1'b0;
        @(negedge mclk);
        check(!locked && !ps_rdy && !wb_ack, "outputs not low after reset");
        wb_read(REG_CTRL, rd);
        check(rd == 32'd1, $sformatf("REG_CTRL reads %h after reset", rd));
        wb_read(REG_PHASE, rd);
        check(rd == 32'd0, $sformatf("REG_PHASE reads %h after reset", rd));

        wb_write(REG_CTRL, 32'd0);          // release the clock manager
        wait_lock();
        move_to(8'd40);                     // upward
        move_to(8'd13);                     // downward
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_phase(p);
            move_to(p);
        end

        // read-only registers ignore writes
        wb_read(REG_STATUS, status_before);
        wb_read(REG_CURRENT, current_before);
        wb_write(REG_STATUS, ~status_before);
        wb_write(REG_CURRENT, ~current_before);
        wb_read(REG_STATUS, rd);
        check(rd == status_before, $sformatf("REG_STATUS changed to %h", rd));
        wb_read(REG_CURRENT, rd);
        check(rd == current_before, $sformatf("REG_CURRENT changed to %h", rd));

        // clock manager reset and relock
        move_to(8'd77);
        wb_write(REG_CTRL, 32'd1);
        check(!locked && !ps_rdy && ps_out == 8'd0,
              $sformatf("after rst_mmcm locked %b ps_rdy %b phase %0d", locked, ps_rdy, ps_out));
        wb_write(REG_CTRL, 32'd0);
        wait_lock();
        follow_move(8'd77);
        check_readback(8'd77);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge mclk);
        $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+tests
common/hispi_clk_pkg.sv
verilog/hispi_wb_regs.sv
verilog/lock_monitor.sv
phase/phase_step_fsm.sv
phase/phase_shift_port.sv
verilog/sens_hispi_clock_ctrl.sv
tests/tb_hispi_clock.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_hispi_clock \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qx "TEST PASSED" <<< "$out"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
